// File: source/sprite_pkg.sv
// ======================================
// shared definitions for the sprite block
// object entries are 64 bits and the field positions below must match
// the layout that the CPU writes into sprite RAM
// line buffer positions wrap at LINE_WIDTH
// ======================================

package sprite_pkg;

    // ======================================
    // object entry layout
    // ======================================
    localparam int OBJ_Y_LSB      = 0;
    localparam int OBJ_Y_W        = 9;
    localparam int OBJ_CODE_LSB   = 16;
    localparam int OBJ_CODE_W     = 16;
    localparam int OBJ_COLOR_LSB  = 32;
    localparam int OBJ_COLOR_W    = 4;
    localparam int OBJ_FLIPY_BIT  = 42;
    localparam int OBJ_FLIPX_BIT  = 43;
    // height and width are log2 of the size in 16-pixel tiles
    localparam int OBJ_HEIGHT_LSB = 44;
    localparam int OBJ_WIDTH_LSB  = 46;
    localparam int OBJ_SIZE_W     = 2;
    localparam int OBJ_X_LSB      = 48;
    localparam int OBJ_X_W        = 10;

    // scanner FSM
    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_size,
        st_code,
        st_fetch,
        st_draw,
        st_next
    } scan_state_e;

    // ======================================
    // display and memory constants
    // ======================================
    localparam int LINE_WIDTH = 1024;
    localparam int POS_W      = 10;
    // first line buffer position shown on every line
    localparam int SCAN_START = 249;
    localparam int GFX_AW     = 17;

endpackage

// File: source/sprite_ram_dma.sv
// ======================================
// CPU sprite RAM and DMA into the object table
// the CPU must not write while dma_busy is high
// NUM_OBJS * 4 must not exceed the 512 RAM words
// obj_entry follows obj_index after one cycle
// ======================================
`timescale 1ns/1ps

module sprite_ram_dma #(
    parameter int NUM_OBJS = 128,
    localparam int OW = $clog2(NUM_OBJS)
) (
    input  logic          CLK_32M,
    input  logic          arst_n,
    input  logic [8:0]    cpu_addr,
    input  logic [15:0]   cpu_din,
    input  logic [1:0]    cpu_byte_sel,
    input  logic          cpu_wr,
    input  logic          cpu_rd,
    output logic [15:0]   cpu_dout,
    input  logic          dma_start,
    output logic          dma_busy,
    input  logic [OW-1:0] obj_index,
    output logic [63:0]   obj_entry
);

    localparam int DMA_WORDS = NUM_OBJS * 4;
    // two extra cycles cover the RAM read latency and the final table write
    localparam logic [9:0] DMA_LAST = 10'(DMA_WORDS + 1);

    logic [7:0]  ram_lo [512];
    logic [7:0]  ram_hi [512];
    logic [63:0] obj_table [NUM_OBJS];

    logic [9:0]  dma_cnt;
    logic [7:0]  dma_lo;
    logic [7:0]  dma_hi;
    logic        dma_vld;
    logic [8:0]  dma_word;
    logic [47:0] dma_acc;

    // ======================================
    // sprite RAM, CPU port and DMA read port
    // ======================================
    always_ff @(posedge CLK_32M) begin
        if (cpu_wr && cpu_byte_sel[0]) begin
            ram_lo[cpu_addr] <= cpu_din[7:0];
        end
        if (cpu_wr && cpu_byte_sel[1]) begin
            ram_hi[cpu_addr] <= cpu_din[15:8];
        end
        if (cpu_rd) begin
            cpu_dout <= {ram_hi[cpu_addr], ram_lo[cpu_addr]};
        end
        dma_lo <= ram_lo[dma_cnt[8:0]];
        dma_hi <= ram_hi[dma_cnt[8:0]];
    end

    // ======================================
    // DMA sequencing
    // ======================================
    always_ff @(posedge CLK_32M or negedge arst_n) begin
        if (!arst_n) begin
            dma_busy <= 1'b0;
            dma_cnt  <= '0;
            dma_vld  <= 1'b0;
            dma_word <= '0;
        end else begin
            if (dma_start && !dma_busy) begin
                dma_busy <= 1'b1;
                dma_cnt  <= '0;
            end else if (dma_busy) begin
                dma_cnt <= dma_cnt + 10'd1;
                if (dma_cnt == DMA_LAST) begin
                    dma_busy <= 1'b0;
                end
            end
            // the word read this cycle lands in dma_lo/dma_hi next cycle
            dma_vld  <= dma_busy && (dma_cnt < 10'(DMA_WORDS));
            dma_word <= dma_cnt[8:0];
        end
    end

    // words 0..2 shift in from the top, word 3 completes the entry
    always_ff @(posedge CLK_32M) begin
        if (dma_vld) begin
            if (dma_word[1:0] == 2'd3) begin
                obj_table[dma_word[OW+1:2]] <= {dma_hi, dma_lo, dma_acc};
            end else begin
                dma_acc <= {dma_hi, dma_lo, dma_acc[47:16]};
            end
        end
        obj_entry <= obj_table[obj_index];
    end

endmodule

// File: source/sprite_scanner.sv
// ======================================
// per-line object walk and graphics fetch
// one ROM request is outstanding at a time
// work left over at the next line_start is dropped
// ======================================
`timescale 1ns/1ps

module sprite_scanner import sprite_pkg::*; #(
    parameter int NUM_OBJS = 128,
    localparam int OW = $clog2(NUM_OBJS)
) (
    input  logic              CLK_32M,
    input  logic              arst_n,
    input  logic              line_start,
    input  logic [8:0]        vpos,
    input  logic              flip,
    output logic [OW-1:0]     obj_index,
    input  logic [63:0]       obj_entry,
    output logic              gfx_req,
    output logic [GFX_AW-1:0] gfx_addr,
    input  logic [63:0]       gfx_data,
    input  logic              gfx_rdy,
    output logic              draw_strobe,
    output logic [63:0]       draw_data,
    output logic [3:0]        draw_color,
    output logic [POS_W-1:0]  draw_x,
    input  logic              draw_busy
);

    scan_state_e state;
    logic [OW:0]  ptr;
    logic [2:0]   span;
    logic         gfx_pend;
    logic [8:0]   v_line;
    logic [63:0]  cur_obj;
    logic [3:0]   width_t;
    logic [8:0]   height_px;
    logic [8:0]   rel_y;

    logic [8:0]   row_y;
    logic [2:0]   col;
    logic [15:0]  code;
    logic         on_line;
    logic [OW:0]  step;
    logic [2:0]   last_span;
    logic         cur_flipx;
    logic         cur_flipy;

    // 16 pixels arrive as two groups of eight, four byte planes each
    // the result holds plane p in bits 16p+15 down to 16p, leftmost pixel on top
    function automatic logic [63:0] deswizzle(input logic [63:0] d, input logic rev);
        logic [7:0]  b [8];
        logic [63:0] planes;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                b[i][j] = rev ? d[8*i + 7 - j] : d[8*i + j];
            end
        end
        for (int p = 0; p < 4; p++) begin
            planes[16*p +: 16] = rev ? {b[p + 4], b[p]} : {b[p], b[p + 4]};
        end
        return planes;
    endfunction

    assign obj_index = ptr[OW-1:0];
    assign cur_flipx = cur_obj[OBJ_FLIPX_BIT];
    assign cur_flipy = cur_obj[OBJ_FLIPY_BIT];
    assign on_line   = rel_y < height_px;
    assign row_y     = cur_flipy ? (height_px - 9'd1 - rel_y) : rel_y;
    // width 8 wraps to 0 in three bits, which still gives 7 - span
    assign col       = cur_flipx ? (width_t[2:0] - 3'd1 - span) : span;
    assign code      = cur_obj[OBJ_CODE_LSB +: OBJ_CODE_W] + {11'd0, row_y[8:4]}
                       + {10'd0, col, 3'd0};
    assign step      = (OW + 1)'(width_t);
    assign last_span = width_t[2:0] - 3'd1;

    // ======================================
    // FSM and request strobes
    // ======================================
    always_ff @(posedge CLK_32M or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            ptr         <= '0;
            span        <= '0;
            gfx_req     <= 1'b0;
            gfx_pend    <= 1'b0;
            draw_strobe <= 1'b0;
        end else begin
            gfx_req     <= 1'b0;
            draw_strobe <= 1'b0;
            // a stale answer from an aborted line still has to be absorbed
            if (gfx_rdy) begin
                gfx_pend <= 1'b0;
            end
            if (line_start) begin
                state <= st_load;
                ptr   <= '0;
            end else begin
                case (state)
                    st_load: begin
                        state <= (ptr >= NUM_OBJS) ? st_idle : st_size;
                    end
                    st_size: begin
                        span  <= '0;
                        state <= st_code;
                    end
                    st_code: begin
                        if (!on_line) begin
                            ptr   <= ptr + step;
                            state <= st_load;
                        end else if (!gfx_pend) begin
                            gfx_req  <= 1'b1;
                            gfx_pend <= 1'b1;
                            state    <= st_fetch;
                        end
                    end
                    st_fetch: begin
                        if (gfx_rdy) begin
                            state <= st_draw;
                        end
                    end
                    st_draw: begin
                        if (!draw_busy) begin
                            draw_strobe <= 1'b1;
                            state       <= st_next;
                        end
                    end
                    st_next: begin
                        if (span == last_span) begin
                            ptr   <= ptr + step;
                            state <= st_load;
                        end else begin
                            span  <= span + 3'd1;
                            state <= st_code;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // ======================================
    // object and span data path
    // ======================================
    always_ff @(posedge CLK_32M) begin
        if (line_start) begin
            v_line <= flip ? (vpos - 9'd1) : (vpos + 9'd1);
        end
        case (state)
            st_size: begin
                cur_obj   <= obj_entry;
                width_t   <= 4'd1 << obj_entry[OBJ_WIDTH_LSB +: OBJ_SIZE_W];
                height_px <= 9'd16 << obj_entry[OBJ_HEIGHT_LSB +: OBJ_SIZE_W];
                // offset by the height so objects above the top wrap correctly
                rel_y     <= v_line + obj_entry[OBJ_Y_LSB +: OBJ_Y_W]
                             + (9'd16 << obj_entry[OBJ_HEIGHT_LSB +: OBJ_SIZE_W]);
            end
            st_code: begin
                gfx_addr <= GFX_AW'({code, row_y[3:0]});
            end
            st_fetch: begin
                if (gfx_rdy) begin
                    draw_data <= deswizzle(gfx_data, cur_flipx);
                end
            end
            st_draw: begin
                draw_color <= cur_obj[OBJ_COLOR_LSB +: OBJ_COLOR_W];
                draw_x     <= cur_obj[OBJ_X_LSB +: OBJ_X_W] + {3'd0, span, 4'd0};
            end
            default: ;
        endcase
    end

endmodule

// File: source/line_buffer.sv
// ======================================
// three rotating line RAMs: shown, drawn and cleared
// a draw that is still running at line_start may land in the wrong RAM
// the output stays zero until the first full clear after reset
// ======================================
`timescale 1ns/1ps

module line_buffer import sprite_pkg::*; (
    input  logic             CLK_32M,
    input  logic             arst_n,
    input  logic             line_start,
    input  logic             flip,
    input  logic             ce_pix,
    input  logic             draw_strobe,
    input  logic [63:0]      draw_data,
    input  logic [3:0]       draw_color,
    input  logic [POS_W-1:0] draw_x,
    output logic             draw_busy,
    output logic [7:0]       pixel
);

    logic [1:0]       sel;
    logic [1:0]       drawn_sel;
    logic [1:0]       clear_sel;
    // the top bit marks a finished clear walk
    logic [POS_W:0]   clr_pos;
    logic             clr_all;

    logic [4:0]       shift_cnt;
    logic [63:0]      shift_data;
    logic [3:0]       shift_color;
    logic [POS_W-1:0] shift_pos;
    logic [3:0]       shift_idx;

    logic             pix_we;
    logic [7:0]       pix_wdata;
    logic [POS_W-1:0] pix_pos;

    logic [POS_W-1:0] scan_pos;
    logic [POS_W-1:0] scan_addr;
    logic [7:0]       rd_q [3];

    // the drawn RAM becomes the shown one at the next rotation
    assign drawn_sel = (sel == 2'd2) ? 2'd0 : sel + 2'd1;
    assign clear_sel = (sel == 2'd0) ? 2'd2 : sel - 2'd1;
    assign scan_addr = scan_pos ^ {POS_W{flip}};
    assign draw_busy = shift_cnt != 5'd0;
    assign shift_idx = {shift_data[63], shift_data[47], shift_data[31], shift_data[15]};

    // ======================================
    // line RAMs
    // ======================================
    for (genvar i = 0; i < 3; i++) begin : g_ram
        logic [7:0] mem [LINE_WIDTH];
        logic       clr_we;

        // after reset every RAM is cleared, later only the one in the clear role
        assign clr_we = !clr_pos[POS_W] && (clr_all || clear_sel == 2'(i));

        always_ff @(posedge CLK_32M) begin
            if (clr_we) begin
                mem[clr_pos[POS_W-1:0]] <= 8'd0;
            end else if (pix_we && drawn_sel == 2'(i)) begin
                mem[pix_pos] <= pix_wdata;
            end
            if (ce_pix) begin
                rd_q[i] <= mem[scan_addr];
            end
        end
    end

    // ======================================
    // rotation, clear walk, scan-out and draw control
    // ======================================
    always_ff @(posedge CLK_32M or negedge arst_n) begin
        if (!arst_n) begin
            sel       <= 2'd0;
            clr_pos   <= '0;
            clr_all   <= 1'b1;
            scan_pos  <= POS_W'(SCAN_START);
            pixel     <= 8'd0;
            shift_cnt <= 5'd0;
            pix_we    <= 1'b0;
        end else begin
            if (line_start) begin
                sel      <= drawn_sel;
                clr_pos  <= '0;
                scan_pos <= POS_W'(SCAN_START);
            end else begin
                if (!clr_pos[POS_W]) begin
                    clr_pos <= clr_pos + 1'b1;
                end else begin
                    clr_all <= 1'b0;
                end
                if (ce_pix) begin
                    pixel    <= clr_all ? 8'd0 : rd_q[sel];
                    scan_pos <= scan_pos + 1'b1;
                end
            end

            // index zero is transparent and never written
            pix_we <= draw_busy && (shift_idx != 4'd0);
            if (draw_busy) begin
                shift_cnt <= shift_cnt - 5'd1;
            end else if (draw_strobe) begin
                shift_cnt <= 5'd16;
            end
        end
    end

    // leftmost pixel sits in the top bit of each plane
    always_ff @(posedge CLK_32M) begin
        if (draw_busy) begin
            pix_wdata  <= {shift_color, shift_idx};
            pix_pos    <= shift_pos;
            shift_pos  <= shift_pos + 1'b1;
            shift_data <= {shift_data[62:0], 1'b0};
        end else if (draw_strobe) begin
            shift_data  <= draw_data;
            shift_color <= draw_color;
            shift_pos   <= draw_x;
        end
    end

endmodule

// File: source/sprite_top.sv
// ======================================
// sprite block top level, single clock
// the graphics ROM is addressed in 64-bit words
// ======================================
`timescale 1ns/1ps

module sprite_top import sprite_pkg::*; #(
    parameter int NUM_OBJS = 128
) (
    input  logic              CLK_32M,
    input  logic              arst_n,
    input  logic [8:0]        cpu_addr,
    input  logic [15:0]       cpu_din,
    input  logic [1:0]        cpu_byte_sel,
    input  logic              cpu_wr,
    input  logic              cpu_rd,
    output logic [15:0]       cpu_dout,
    input  logic              dma_start,
    output logic              dma_busy,
    input  logic              line_start,
    input  logic [8:0]        vpos,
    input  logic              flip,
    input  logic              ce_pix,
    output logic [7:0]        pixel,
    output logic              gfx_req,
    output logic [GFX_AW-1:0] gfx_addr,
    input  logic [63:0]       gfx_data,
    input  logic              gfx_rdy
);

    localparam int OW = $clog2(NUM_OBJS);

    logic [OW-1:0]    obj_index;
    logic [63:0]      obj_entry;
    logic             draw_strobe;
    logic [63:0]      draw_data;
    logic [3:0]       draw_color;
    logic [POS_W-1:0] draw_x;
    logic             draw_busy;

    sprite_ram_dma #(
        .NUM_OBJS (NUM_OBJS)
    ) i_ram_dma (
        .CLK_32M      (CLK_32M),
        .arst_n       (arst_n),
        .cpu_addr     (cpu_addr),
        .cpu_din      (cpu_din),
        .cpu_byte_sel (cpu_byte_sel),
        .cpu_wr       (cpu_wr),
        .cpu_rd       (cpu_rd),
        .cpu_dout     (cpu_dout),
        .dma_start    (dma_start),
        .dma_busy     (dma_busy),
        .obj_index    (obj_index),
        .obj_entry    (obj_entry)
    );

    sprite_scanner #(
        .NUM_OBJS (NUM_OBJS)
    ) i_scanner (
        .CLK_32M     (CLK_32M),
        .arst_n      (arst_n),
        .line_start  (line_start),
        .vpos        (vpos),
        .flip        (flip),
        .obj_index   (obj_index),
        .obj_entry   (obj_entry),
        .gfx_req     (gfx_req),
        .gfx_addr    (gfx_addr),
        .gfx_data    (gfx_data),
        .gfx_rdy     (gfx_rdy),
        .draw_strobe (draw_strobe),
        .draw_data   (draw_data),
        .draw_color  (draw_color),
        .draw_x      (draw_x),
        .draw_busy   (draw_busy)
    );

    line_buffer i_line_buffer (
        .CLK_32M     (CLK_32M),
        .arst_n      (arst_n),
        .line_start  (line_start),
        .flip        (flip),
        .ce_pix      (ce_pix),
        .draw_strobe (draw_strobe),
        .draw_data   (draw_data),
        .draw_color  (draw_color),
        .draw_x      (draw_x),
        .draw_busy   (draw_busy),
        .pixel       (pixel)
    );

endmodule

// File: verif/tb_sprite_model.svh
// ========================================
// testbench model for the sprite block
// included inside tb_sprite, uses its obj_list, draw_exp and TB_OBJS
// in a graphics word byte p holds plane p of pixels 0..7, msb first,
// and byte p+4 holds plane p of pixels 8..15
// ========================================
`ifndef TB_SPRITE_MODEL_SVH
`define TB_SPRITE_MODEL_SVH

// 16-bit Galois LFSR, one step per random bit
function automatic logic [15:0] lfsr_next(input logic [15:0] st);
    logic [15:0] nx;
    nx = st >> 1;
    if (st[0]) begin
        nx = nx ^ 16'hb400;
    end
    return nx;
endfunction

// ROM content, about half of the pixels come out transparent
function automatic logic [63:0] gfx_word(input logic [16:0] addr);
    logic [15:0] a;
    logic [63:0] raw;
    logic [7:0]  mlo;
    logic [7:0]  mhi;
    a   = addr[15:0] ^ {addr[16], 15'd0};
    raw = {16'(a * 16'h9e37), a ^ 16'h5aa5, 16'(a * 16'h0d05 + 16'h1234),
           {a[7:0], a[15:8]} ^ 16'hc3f0};
    mlo = addr[7:0] ^ addr[16:9];
    mhi = addr[8:1] ^ 8'h96;
    return raw & {{4{mhi}}, {4{mlo}}};
endfunction

// four-bit index of pixel px, counted from the left
function automatic logic [3:0] plane_index(input logic [63:0] word, input int px);
    logic [3:0] idx;
    for (int p = 0; p < 4; p++) begin
        idx[p] = (px < 8) ? word[8 * p + 7 - px] : word[8 * (p + 4) + 15 - px];
    end
    return idx;
endfunction

// draws the expected line for target line v into draw_exp
task automatic render_line(input int v);
    int          ptr;
    int          h;
    int          w;
    int          rel;
    int          row;
    int          col;
    int          code;
    int          addr;
    int          src;
    int          pos;
    logic [63:0] e;
    logic [63:0] word;
    logic [3:0]  idx;
    for (int i = 0; i < LINE_WIDTH; i++) begin
        draw_exp[i] = 8'd0;
    end
    ptr = 0;
    while (ptr < TB_OBJS) begin
        e   = obj_list[ptr];
        h   = 16 << e[OBJ_HEIGHT_LSB +: OBJ_SIZE_W];
        w   = 1 << e[OBJ_WIDTH_LSB +: OBJ_SIZE_W];
        rel = (v + int'(e[OBJ_Y_LSB +: OBJ_Y_W]) + h) % 512;
        if (rel < h) begin
            row = e[OBJ_FLIPY_BIT] ? h - 1 - rel : rel;
            for (int s = 0; s < w; s++) begin
                col  = e[OBJ_FLIPX_BIT] ? w - 1 - s : s;
                code = (int'(e[OBJ_CODE_LSB +: OBJ_CODE_W]) + row / 16 + 8 * col) % 65536;
                addr = (code * 16 + row % 16) % 131072;
                word = gfx_word(17'(addr));
                for (int p = 0; p < 16; p++) begin
                    src = e[OBJ_FLIPX_BIT] ? 15 - p : p;
                    idx = plane_index(word, src);
                    pos = (int'(e[OBJ_X_LSB +: OBJ_X_W]) + 16 * s + p) % LINE_WIDTH;
                    if (idx != 4'd0) begin
                        draw_exp[pos] = {e[OBJ_COLOR_LSB +: OBJ_COLOR_W], idx};
                    end
                end
            end
        end
        ptr = ptr + w;
    end
endtask

`endif

// File: verif/tb_sprite.sv
// ========================================
// testbench for sprite_top with 16 objects
// ce_pix is high on every cycle and lines are 1200 cycles long
// each line test starts with one unchecked lead-in line
// ========================================
`timescale 1ns/1ps

module tb_sprite import sprite_pkg::*; ();

    localparam int TB_OBJS     = 16;
    localparam int LINE_CYCLES = 1200;
    localparam int LAST_K      = 383;
    localparam int RB_WORDS    = 64;
    localparam int DMA_CYCLES  = TB_OBJS * 4 + 2;
    localparam int LOAD_CYCLES = TB_OBJS * 4 + DMA_CYCLES + 4;
    localparam int LINE_TEST   = 22 * LINE_CYCLES + LOAD_CYCLES;
    localparam int CLEAR_TEST  = 5 * LINE_CYCLES + LOAD_CYCLES;
    localparam int TEST_SUM    = 8 + LINE_CYCLES + RB_WORDS * 4 + DMA_CYCLES + 10
                                 + 3 * LINE_TEST + CLEAR_TEST;
    localparam int RUN_LIMIT   = TEST_SUM * 3 / 2;

    logic              CLK_32M;
    logic              arst_n;
    logic [8:0]        cpu_addr;
    logic [15:0]       cpu_din;
    logic [1:0]        cpu_byte_sel;
    logic              cpu_wr;
    logic              cpu_rd;
    logic [15:0]       cpu_dout;
    logic              dma_start;
    logic              dma_busy;
    logic              line_start;
    logic [8:0]        vpos;
    logic              flip;
    logic              ce_pix;
    logic [7:0]        pixel;
    logic              gfx_req;
    logic [GFX_AW-1:0] gfx_addr;
    logic [63:0]       gfx_data;
    logic              gfx_rdy;

    logic [15:0] rng_main = 16'd14905;
    logic [15:0] rng_rom  = 16'd14905;
    logic [63:0] obj_list [TB_OBJS];
    logic [7:0]  draw_exp [LINE_WIDTH];
    logic [7:0]  shown_exp [LINE_WIDTH];
    logic [15:0] ram_model [512];
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          failed_tests = 0;
    int          cycle_cnt = 0;

    `include "tb_sprite_model.svh"

    sprite_top #(
        .NUM_OBJS (TB_OBJS)
    ) i_dut (
        .CLK_32M      (CLK_32M),
        .arst_n       (arst_n),
        .cpu_addr     (cpu_addr),
        .cpu_din      (cpu_din),
        .cpu_byte_sel (cpu_byte_sel),
        .cpu_wr       (cpu_wr),
        .cpu_rd       (cpu_rd),
        .cpu_dout     (cpu_dout),
        .dma_start    (dma_start),
        .dma_busy     (dma_busy),
        .line_start   (line_start),
        .vpos         (vpos),
        .flip         (flip),
        .ce_pix       (ce_pix),
        .pixel        (pixel),
        .gfx_req      (gfx_req),
        .gfx_addr     (gfx_addr),
        .gfx_data     (gfx_data),
        .gfx_rdy      (gfx_rdy)
    );

    initial begin
        CLK_32M = 1'b0;
        forever #10 CLK_32M = ~CLK_32M;
    end

    always @(posedge CLK_32M) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == RUN_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", RUN_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // ========================================
    // graphics ROM, one answer per request after 1 to 4 cycles
    // ========================================
    initial begin : rom_responder
        logic [16:0] req_addr;
        int          delay;
        gfx_rdy  = 1'b0;
        gfx_data = '0;
        forever begin
            @(negedge CLK_32M);
            gfx_rdy = 1'b0;
            if (gfx_req) begin
                req_addr = gfx_addr;
                delay    = 1;
                for (int i = 0; i < 2; i++) begin
                    delay   = delay + (int'(rng_rom[0]) << i);
                    rng_rom = lfsr_next(rng_rom);
                end
                repeat (delay) @(negedge CLK_32M);
                gfx_data = gfx_word(req_addr);
                gfx_rdy  = 1'b1;
            end
        end
    end

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r        = (r << 1) | int'(rng_main[0]);
            rng_main = lfsr_next(rng_main);
        end
        return r;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what, input int where);
        chk_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("FAILED at time %0t: %s %0d, got %0h, expected %0h",
                     $time, what, where, got, exp);
        end
    endtask

    task automatic report_test(input int num, input string name, input int base);
        if (err_cnt != base) begin
            failed_tests++;
        end
        $display("test %0d (%s) finished with %0d errors", num, name, err_cnt - base);
    endtask

    // all bus tasks start and end on a falling edge
    task automatic cpu_write(input logic [8:0] a, input logic [15:0] d,
                             input logic [1:0] sel);
        cpu_addr     = a;
        cpu_din      = d;
        cpu_byte_sel = sel;
        cpu_wr       = 1'b1;
        @(negedge CLK_32M);
        cpu_wr = 1'b0;
    endtask

    task automatic read_check(input logic [8:0] a);
        cpu_addr = a;
        cpu_rd   = 1'b1;
        @(negedge CLK_32M);
        cpu_rd = 1'b0;
        check_value(cpu_dout, ram_model[a], "cpu_dout at word", a);
    endtask

    task automatic run_dma();
        dma_start = 1'b1;
        @(negedge CLK_32M);
        dma_start = 1'b0;
        while (dma_busy) begin
            @(negedge CLK_32M);
        end
    endtask

    // objects cover lines top to top plus height minus 1
    task automatic load_sprites(input logic use_flips, input int top_min);
        logic [63:0] e;
        int          top;
        int          hl;
        for (int n = 0; n < TB_OBJS; n++) begin
            e   = '0;
            hl  = rand_bits(1);
            top = top_min + rand_bits(6);
            e[OBJ_HEIGHT_LSB +: OBJ_SIZE_W] = 2'(hl);
            e[OBJ_WIDTH_LSB +: OBJ_SIZE_W]  = 2'(rand_bits(1));
            e[OBJ_Y_LSB +: OBJ_Y_W]         = 9'(512 - top - (16 << hl));
            e[OBJ_CODE_LSB +: OBJ_CODE_W]   = 16'(rand_bits(16));
            e[OBJ_COLOR_LSB +: OBJ_COLOR_W] = 4'(rand_bits(4));
            e[OBJ_X_LSB +: OBJ_X_W]         = 10'(232 + rand_bits(9));
            if (use_flips) begin
                e[OBJ_FLIPX_BIT] = 1'(rand_bits(1));
                e[OBJ_FLIPY_BIT] = 1'(rand_bits(1));
            end
            obj_list[n] = e;
            for (int w = 0; w < 4; w++) begin
                cpu_write(9'(4 * n + w), e[16 * w +: 16], 2'b11);
                ram_model[4 * n + w] = e[16 * w +: 16];
            end
        end
        run_dma();
    endtask

    // one lead-in line, then count checked lines from first_v
    task automatic run_lines(input int first_v, input int count, input logic flip_on);
        int v;
        int k;
        int pos;
        for (int n = 0; n <= count; n++) begin
            v = first_v - 1 + n;
            for (int i = 0; i < LINE_WIDTH; i++) begin
                shown_exp[i] = draw_exp[i];
            end
            render_line(flip_on ? (v + 511) % 512 : (v + 1) % 512);
            line_start = 1'b1;
            vpos       = 9'(v);
            flip       = flip_on;
            @(negedge CLK_32M);
            line_start = 1'b0;
            for (int c = 1; c < LINE_CYCLES; c++) begin
                @(negedge CLK_32M);
                k = c - 1;
                if (n > 0 && k >= 1 && k <= LAST_K) begin
                    pos = (SCAN_START + k - 1) ^ (flip_on ? LINE_WIDTH - 1 : 0);
                    check_value(pixel, shown_exp[pos], "pixel on line", v);
                end
            end
        end
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        logic [8:0]  a;
        logic [15:0] d;
        logic [1:0]  sel;
        int          base;
        int          busy_len;
        arst_n       = 1'b0;
        cpu_addr     = '0;
        cpu_din      = '0;
        cpu_byte_sel = '0;
        cpu_wr       = 1'b0;
        cpu_rd       = 1'b0;
        dma_start    = 1'b0;
        line_start   = 1'b0;
        vpos         = '0;
        flip         = 1'b0;
        ce_pix       = 1'b1;
        for (int i = 0; i < LINE_WIDTH; i++) begin
            draw_exp[i] = 8'd0;
        end
        repeat (4) @(negedge CLK_32M);
        arst_n = 1'b1;
        // the line RAMs clear themselves after reset
        repeat (LINE_CYCLES) @(negedge CLK_32M);

        base = err_cnt;
        for (int i = 0; i < RB_WORDS; i++) begin
            a = 9'(i * 37);
            d = 16'(rand_bits(16));
            cpu_write(a, d, 2'b11);
            ram_model[a] = d;
        end
        for (int i = 0; i < RB_WORDS; i++) begin
            a   = 9'(rand_bits(6) * 37);
            d   = 16'(rand_bits(16));
            sel = 2'(rand_bits(2));
            cpu_write(a, d, sel);
            if (sel[0]) begin
                ram_model[a][7:0] = d[7:0];
            end
            if (sel[1]) begin
                ram_model[a][15:8] = d[15:8];
            end
        end
        for (int i = 0; i < RB_WORDS; i++) begin
            read_check(9'(i * 37));
        end
        report_test(1, "cpu read-back", base);

        // a second start in the middle of the copy must not extend it
        base      = err_cnt;
        dma_start = 1'b1;
        @(negedge CLK_32M);
        dma_start = 1'b0;
        busy_len  = 0;
        while (dma_busy) begin
            busy_len++;
            dma_start = (busy_len == 10);
            @(negedge CLK_32M);
        end
        dma_start = 1'b0;
        check_value(busy_len, DMA_CYCLES, "dma_busy cycles, objects", TB_OBJS);
        repeat (3) @(negedge CLK_32M);
        check_value(dma_busy, 1'b0, "dma_busy after copy, objects", TB_OBJS);
        report_test(2, "dma timing", base);

        base = err_cnt;
        load_sprites(1'b0, 0);
        run_lines(20, 21, 1'b0);
        report_test(3, "unflipped objects", base);

        base = err_cnt;
        load_sprites(1'b1, 0);
        run_lines(20, 21, 1'b0);
        report_test(4, "flipped objects", base);

        base = err_cnt;
        load_sprites(1'b0, 0);
        run_lines(20, 21, 1'b1);
        report_test(5, "screen flip", base);

        base = err_cnt;
        load_sprites(1'b0, 200);
        run_lines(50, 4, 1'b0);
        report_test(6, "line clearing", base);

        $display("6 tests run, %0d with errors, %0d checks, %0d errors",
                 failed_tests, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+verif
source/sprite_pkg.sv
source/sprite_ram_dma.sv
source/sprite_scanner.sv
source/line_buffer.sv
source/sprite_top.sv
verif/tb_sprite.sv

// File: Bender.yml
package:
  name: sprite_block

sources:
  - source/sprite_pkg.sv
  - source/sprite_ram_dma.sv
  - source/sprite_scanner.sv
  - source/line_buffer.sv
  - source/sprite_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_sprite.sv
